//--- fm_pkg.sv
// FM operator register block
// Shared types and address map

package fm_pkg;

	typedef logic [4:0] slot_t;    // {op[1:0], ch[2:0]}
	typedef logic [2:0] ch_t;
	typedef logic [7:0] fm_addr_t;
	typedef logic [7:0] fm_data_t;

	// Register group targeted by a host write
	typedef enum logic [3:0] {
		UPD_NONE,
		UPD_KEYON,
		UPD_CH_CTRL,
		UPD_KC,
		UPD_KF,
		UPD_DT1_MUL,
		UPD_TL,
		UPD_KS_AR,
		UPD_D1L_RR
	} upd_kind_t;

	typedef enum logic [1:0] {
		SCAN_IDLE,
		SCAN_WAIT,    // Waiting for slot 0
		SCAN_APPLY    // Commit round
	} scan_state_t;

	typedef struct packed {
		upd_kind_t kind;
		slot_t     slot;
		fm_data_t  data;
	} fm_write_t;

	typedef struct packed {
		logic [2:0] dt1;
		logic [3:0] mul;
		logic [6:0] tl;
		logic [1:0] ks;
		logic [4:0] ar;
		logic [3:0] d1l;
		logic [3:0] rr;
	} op_params_t;

	typedef struct packed {
		logic [1:0] rl;
		logic [2:0] fb;
		logic [2:0] con;    // Algorithm
		logic [6:0] kc;
		logic [5:0] kf;
	} ch_params_t;

	typedef struct packed {
		slot_t      slot;
		op_params_t op;
		ch_params_t ch;
		logic       keyon;
		logic       carrier;
	} slot_out_t;

	// Address map
	localparam fm_addr_t ADDR_KEYON   = 8'h08;
	localparam fm_addr_t ADDR_CH_CTRL = 8'h20;
	localparam fm_addr_t ADDR_KC      = 8'h28;
	localparam fm_addr_t ADDR_KF      = 8'h30;
	localparam fm_addr_t ADDR_DT1_MUL = 8'h40;
	localparam fm_addr_t ADDR_TL      = 8'h60;
	localparam fm_addr_t ADDR_KS_AR   = 8'h80;
	localparam fm_addr_t ADDR_D1L_RR  = 8'hE0;
	localparam fm_addr_t CH_GRP_MASK  = 8'hF8;    // 8 channels per group
	localparam fm_addr_t OP_GRP_MASK  = 8'hE0;    // 32 slots per group

endpackage

//--- fm_scan_ctrl.sv
// Scan control
// Slot counter, address decode and busy FSM
`timescale 1ns/1ps

module fm_scan_ctrl (
	input  logic              clk,
	input  logic              rst,
	input  logic              wr,
	input  fm_pkg::fm_addr_t  addr,
	input  fm_pkg::fm_data_t  din,
	output logic              busy,
	output fm_pkg::slot_t     cur_slot,
	output logic              apply,
	output fm_pkg::fm_write_t pend
);

	fm_pkg::scan_state_t state;
	fm_pkg::scan_state_t state_nx;
	fm_pkg::upd_kind_t   dec_kind;
	fm_pkg::slot_t       dec_slot;
	logic                take;

	// Address decode
	always_comb begin
		dec_kind = fm_pkg::UPD_NONE;
		dec_slot = addr[4:0];    // Operator groups use the full slot
		if (addr == fm_pkg::ADDR_KEYON)
			dec_kind = fm_pkg::UPD_KEYON;
		else if ((addr & fm_pkg::CH_GRP_MASK) == fm_pkg::ADDR_CH_CTRL)
			dec_kind = fm_pkg::UPD_CH_CTRL;
		else if ((addr & fm_pkg::CH_GRP_MASK) == fm_pkg::ADDR_KC)
			dec_kind = fm_pkg::UPD_KC;
		else if ((addr & fm_pkg::CH_GRP_MASK) == fm_pkg::ADDR_KF)
			dec_kind = fm_pkg::UPD_KF;
		else if ((addr & fm_pkg::OP_GRP_MASK) == fm_pkg::ADDR_DT1_MUL)
			dec_kind = fm_pkg::UPD_DT1_MUL;
		else if ((addr & fm_pkg::OP_GRP_MASK) == fm_pkg::ADDR_TL)
			dec_kind = fm_pkg::UPD_TL;
		else if ((addr & fm_pkg::OP_GRP_MASK) == fm_pkg::ADDR_KS_AR)
			dec_kind = fm_pkg::UPD_KS_AR;
		else if ((addr & fm_pkg::OP_GRP_MASK) == fm_pkg::ADDR_D1L_RR)
			dec_kind = fm_pkg::UPD_D1L_RR;

		// Channel groups only carry the channel
		if (dec_kind == fm_pkg::UPD_CH_CTRL || dec_kind == fm_pkg::UPD_KC ||
				dec_kind == fm_pkg::UPD_KF)
			dec_slot = {2'b00, addr[2:0]};
	end

	assign take = wr && !busy && dec_kind != fm_pkg::UPD_NONE;

	always_comb begin
		state_nx = state;
		case (state)
			fm_pkg::SCAN_IDLE: begin
				if (take)
					state_nx = fm_pkg::SCAN_WAIT;
			end
			fm_pkg::SCAN_WAIT: begin
				if (&cur_slot)    // Round starts on the wrap
					state_nx = fm_pkg::SCAN_APPLY;
			end
			fm_pkg::SCAN_APPLY: begin
				if (&cur_slot)
					state_nx = fm_pkg::SCAN_IDLE;
			end
			default: state_nx = fm_pkg::SCAN_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= fm_pkg::SCAN_IDLE;
			cur_slot  <= '0;
			pend.kind <= fm_pkg::UPD_NONE;
		end else begin
			state    <= state_nx;
			cur_slot <= cur_slot + 5'd1;    // Free running, wraps at 31
			if (take)
				pend <= '{kind: dec_kind, slot: dec_slot, data: din};
		end
	end

	assign busy  = state != fm_pkg::SCAN_IDLE;
	assign apply = state == fm_pkg::SCAN_APPLY;

endmodule

//--- fm_slot_regs.sv
// Slot memories
// Operator and channel parameter storage
`timescale 1ns/1ps

module fm_slot_regs (
	input  logic               clk,
	input  fm_pkg::slot_t      cur_slot,
	input  logic               apply,
	input  fm_pkg::fm_write_t  pend,
	output fm_pkg::slot_t      rd_slot,
	output fm_pkg::op_params_t op_q,
	output fm_pkg::ch_params_t ch_q
);

	fm_pkg::op_params_t op_mem [32];
	fm_pkg::ch_params_t ch_mem [8];

	fm_pkg::slot_t      next_slot;
	fm_pkg::ch_t        cur_ch;
	fm_pkg::ch_t        next_ch;
	fm_pkg::op_params_t op_new;
	fm_pkg::ch_params_t ch_new;
	logic               op_hit;
	logic               ch_hit;
	logic               op_sel;
	logic               ch_sel;

	assign next_slot = cur_slot + 5'd1;
	assign cur_ch    = cur_slot[2:0];
	assign next_ch   = next_slot[2:0];

	assign op_hit = cur_slot == pend.slot;       // Once per round
	assign ch_hit = cur_ch == pend.slot[2:0];    // Four times per round

	// Operator merge, other fields kept from the read value
	always_comb begin
		op_new = op_q;
		op_sel = 1'b0;
		case (pend.kind)
			fm_pkg::UPD_DT1_MUL: begin
				op_new.dt1 = pend.data[6:4];
				op_new.mul = pend.data[3:0];
				op_sel     = op_hit;
			end
			fm_pkg::UPD_TL: begin
				op_new.tl = pend.data[6:0];
				op_sel    = op_hit;
			end
			fm_pkg::UPD_KS_AR: begin
				op_new.ks = pend.data[7:6];
				op_new.ar = pend.data[4:0];
				op_sel    = op_hit;
			end
			fm_pkg::UPD_D1L_RR: begin
				op_new.d1l = pend.data[7:4];
				op_new.rr  = pend.data[3:0];
				op_sel     = op_hit;
			end
			default: op_sel = 1'b0;
		endcase
	end

	// Channel merge
	always_comb begin
		ch_new = ch_q;
		ch_sel = 1'b0;
		case (pend.kind)
			fm_pkg::UPD_CH_CTRL: begin
				ch_new.rl  = pend.data[7:6];
				ch_new.fb  = pend.data[5:3];
				ch_new.con = pend.data[2:0];
				ch_sel     = ch_hit;
			end
			fm_pkg::UPD_KC: begin
				ch_new.kc = pend.data[6:0];
				ch_sel    = ch_hit;
			end
			fm_pkg::UPD_KF: begin
				ch_new.kf = pend.data[7:2];
				ch_sel    = ch_hit;
			end
			default: ch_sel = 1'b0;
		endcase
	end

	// Read one slot ahead so the outputs line up with cur_slot
	always_ff @(posedge clk) begin
		rd_slot <= next_slot;
		op_q    <= op_mem[next_slot];
		ch_q    <= ch_mem[next_ch];
		if (apply && op_sel)
			op_mem[cur_slot] <= op_new;
		if (apply && ch_sel)
			ch_mem[cur_ch] <= ch_new;
	end

endmodule

//--- fm_keyon.sv
// Key-on flags
`timescale 1ns/1ps

module fm_keyon (
	input  logic              clk,
	input  logic              rst,
	input  fm_pkg::slot_t     cur_slot,
	input  logic              apply,
	input  fm_pkg::fm_write_t pend,
	output logic              kon_q
);

	logic [31:0]   flags;    // One per slot
	logic [3:0]    kon_mask;
	fm_pkg::ch_t   kon_ch;
	fm_pkg::slot_t next_slot;
	logic          kon_hit;

	assign kon_mask  = pend.data[6:3];    // Bit per operator M1..C2
	assign kon_ch    = pend.data[2:0];
	assign next_slot = cur_slot + 5'd1;

	// Only the four slots of the target channel change
	assign kon_hit = apply && pend.kind == fm_pkg::UPD_KEYON &&
		cur_slot[2:0] == kon_ch;

	always_ff @(posedge clk) begin
		if (rst) begin
			flags <= '0;
			kon_q <= 1'b0;
		end else begin
			kon_q <= flags[next_slot];    // Same timing as op_q
			if (kon_hit)
				flags[cur_slot] <= kon_mask[cur_slot[4:3]];
		end
	end

endmodule

//--- fm_slot_out.sv
// Slot output stage
// Registers the slot record, decodes carrier from CON
`timescale 1ns/1ps

module fm_slot_out (
	input  logic               clk,
	input  fm_pkg::slot_t      rd_slot,
	input  fm_pkg::op_params_t op_q,
	input  fm_pkg::ch_params_t ch_q,
	input  logic               kon_q,
	output fm_pkg::slot_out_t  slot_data
);

	logic [1:0] op;
	logic       carrier;

	assign op = rd_slot[4:3];    // M1, M2, C1, C2

	// Which operators feed the output for each algorithm
	always_comb begin
		case (ch_q.con)
			3'd0, 3'd1, 3'd2, 3'd3: carrier = op == 2'd3;
			3'd4:                   carrier = op[1];
			3'd5, 3'd6:             carrier = op != 2'd0;
			default:                carrier = 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		slot_data <= '{
			slot:    rd_slot,
			op:      op_q,
			ch:      ch_q,
			keyon:   kon_q,
			carrier: carrier
		};
	end

endmodule

//--- fm_regs_top.sv
// FM operator register block top
`timescale 1ns/1ps

module fm_regs_top (
	input  logic              clk,
	input  logic              rst,
	input  logic              wr,
	input  fm_pkg::fm_addr_t  addr,
	input  fm_pkg::fm_data_t  din,
	output logic              busy,
	output fm_pkg::slot_out_t slot_data
);

	fm_pkg::slot_t      cur_slot;
	fm_pkg::slot_t      rd_slot;
	logic               apply;
	fm_pkg::fm_write_t  pend;
	fm_pkg::op_params_t op_q;
	fm_pkg::ch_params_t ch_q;
	logic               kon_q;

	fm_scan_ctrl scan_ctrl_i (
		.clk      (clk),
		.rst      (rst),
		.wr       (wr),
		.addr     (addr),
		.din      (din),
		.busy     (busy),
		.cur_slot (cur_slot),
		.apply    (apply),
		.pend     (pend)
	);

	fm_slot_regs slot_regs_i (
		.clk      (clk),
		.cur_slot (cur_slot),
		.apply    (apply),
		.pend     (pend),
		.rd_slot  (rd_slot),
		.op_q     (op_q),
		.ch_q     (ch_q)
	);

	fm_keyon keyon_i (
		.clk      (clk),
		.rst      (rst),
		.cur_slot (cur_slot),
		.apply    (apply),
		.pend     (pend),
		.kon_q    (kon_q)
	);

	fm_slot_out slot_out_i (
		.clk       (clk),
		.rd_slot   (rd_slot),
		.op_q      (op_q),
		.ch_q      (ch_q),
		.kon_q     (kon_q),
		.slot_data (slot_data)
	);

endmodule

//--- tb_clock.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;    // 8 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (8) @(posedge clk);
		#1 rst = 1'b0;    // Released off the edge like the other inputs
	end

endmodule

//--- tb_fm_regs.sv
// FM register block testbench
// Directed tests against a model of the register map
`timescale 1ns/1ps

module tb_fm_regs;

	// Roughly 73 writes of up to 66 cycles plus readback scans
	localparam int CYCLE_LIMIT = 20000;

	logic              clk;
	logic              rst;
	logic              wr;
	fm_pkg::fm_addr_t  addr;
	fm_pkg::fm_data_t  din;
	logic              busy;
	fm_pkg::slot_out_t slot_data;

	fm_pkg::op_params_t exp_op [32];
	fm_pkg::ch_params_t exp_ch [8];
	logic               exp_kon [32];
	logic [3:0]         op_groups [32];    // Operator groups written per slot
	fm_pkg::slot_t      busy_slot;
	integer             seed;
	int                 checks = 0;
	int                 errors = 0;
	int                 cycles = 0;

	tb_clock clock_i (
		.clk (clk),
		.rst (rst)
	);

	fm_regs_top fm_regs_top_i (
		.clk       (clk),
		.rst       (rst),
		.wr        (wr),
		.addr      (addr),
		.din       (din),
		.busy      (busy),
		.slot_data (slot_data)
	);

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run stopped after %0d cycles without finishing", cycles);
			$display("Done: errors found");
			$finish;
		end
	end

	// Expected state decoded from the address map
	task automatic model_write(input fm_pkg::fm_addr_t a, input fm_pkg::fm_data_t d);
		fm_pkg::ch_t   ch;
		fm_pkg::slot_t s;
		ch = a[2:0];
		s  = a[4:0];
		if (a == 8'h08) begin
			for (int op = 0; op < 4; op++)
				exp_kon[{op[1:0], d[2:0]}] = d[3 + op];
		end else if (a >= 8'h20 && a <= 8'h27) begin
			exp_ch[ch].rl  = d[7:6];
			exp_ch[ch].fb  = d[5:3];
			exp_ch[ch].con = d[2:0];
		end else if (a >= 8'h28 && a <= 8'h2F) begin
			exp_ch[ch].kc = d[6:0];
		end else if (a >= 8'h30 && a <= 8'h37) begin
			exp_ch[ch].kf = d[7:2];
		end else if (a >= 8'h40 && a <= 8'h5F) begin
			exp_op[s].dt1   = d[6:4];
			exp_op[s].mul   = d[3:0];
			op_groups[s][0] = 1'b1;
		end else if (a >= 8'h60 && a <= 8'h7F) begin
			exp_op[s].tl    = d[6:0];
			op_groups[s][1] = 1'b1;
		end else if (a >= 8'h80 && a <= 8'h9F) begin
			exp_op[s].ks    = d[7:6];
			exp_op[s].ar    = d[4:0];
			op_groups[s][2] = 1'b1;
		end else if (a >= 8'hE0) begin
			exp_op[s].d1l   = d[7:4];
			exp_op[s].rr    = d[3:0];
			op_groups[s][3] = 1'b1;
		end
	endtask

	function automatic logic expected_carrier(input logic [2:0] con, input logic [1:0] op);
		logic [3:0] mask;    // Bit per operator with M1 in bit 0
		case (con)
			3'd4:       mask = 4'b1100;
			3'd5, 3'd6: mask = 4'b1110;
			3'd7:       mask = 4'b1111;
			default:    mask = 4'b1000;
		endcase
		return mask[op];
	endfunction

	task automatic strobe_write(input fm_pkg::fm_addr_t a, input fm_pkg::fm_data_t d);
		wr   = 1'b1;
		addr = a;
		din  = d;
		@(posedge clk);
		#1;
		wr = 1'b0;
	endtask

	task automatic wait_idle();
		while (busy) begin
			@(posedge clk);
			#1;
		end
		// Slot 31 record at the fall was read before its commit
		@(posedge clk);
		#1;
	endtask

	task automatic reg_write(input fm_pkg::fm_addr_t a, input fm_pkg::fm_data_t d);
		strobe_write(a, d);
		model_write(a, d);
		wait_idle();
	endtask

	task automatic wait_slot(input fm_pkg::slot_t s);
		while (slot_data.slot !== s) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic check_op(input string name, input fm_pkg::op_params_t exp,
			input fm_pkg::op_params_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_ch(input string name, input fm_pkg::ch_params_t exp,
			input fm_pkg::ch_params_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERROR at %0t ns: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	task automatic end_test(input string name, input int errors_before);
		if (errors == errors_before)
			$display("Test %s: pass", name);
		else
			$display("Test %s: FAIL with %0d errors", name, errors - errors_before);
	endtask

	task automatic check_slot_op(input fm_pkg::slot_t s);
		wait_slot(s);
		check_op($sformatf("slot_data.op[%0d]", s), exp_op[s], slot_data.op);
	endtask

	task automatic scan_keyon();
		for (int s = 0; s < 32; s++) begin
			wait_slot(fm_pkg::slot_t'(s));
			check_bit($sformatf("slot_data.keyon[%0d]", s), exp_kon[s], slot_data.keyon);
		end
	endtask

	task automatic test_reset_state();
		int e0;
		e0 = errors;
		for (int i = 0; i < 32; i++) begin
			check_bit("busy", 1'b0, busy);
			check_bit($sformatf("slot_data.keyon[%0d]", slot_data.slot), 1'b0,
				slot_data.keyon);
			@(posedge clk);
			#1;
		end
		end_test("reset state", e0);
	endtask

	task automatic test_operator_groups();
		fm_pkg::slot_t s;
		logic [31:0]   rnd;
		int            e0;
		e0 = errors;
		s  = '0;
		for (int n = 0; n < 8; n++) begin
			rnd = $random(seed);
			if (n[0])
				s = s + 5'd1;    // Pair with the slot just written
			else
				s = rnd[4:0];
			if (n == 0)
				busy_slot = s;
			reg_write({3'b010, s}, rnd[15:8]);
			reg_write({3'b011, s}, rnd[23:16]);
			reg_write({3'b100, s}, rnd[31:24]);
			rnd = $random(seed);
			reg_write({3'b111, s}, rnd[7:0]);
			check_slot_op(s);
			if (&op_groups[s + 5'd1])    // Neighbors written earlier
				check_slot_op(s + 5'd1);
			if (&op_groups[s - 5'd1])
				check_slot_op(s - 5'd1);
		end
		for (int i = 0; i < 32; i++)
			if (&op_groups[i])
				check_slot_op(fm_pkg::slot_t'(i));
		end_test("operator groups", e0);
	endtask

	task automatic test_channel_groups();
		logic [31:0] rnd;
		int          e0;
		e0 = errors;
		for (int c = 0; c < 8; c++) begin
			rnd = $random(seed);
			reg_write({5'b00100, fm_pkg::ch_t'(c)}, rnd[7:0]);
			reg_write({5'b00101, fm_pkg::ch_t'(c)}, rnd[15:8]);
			reg_write({5'b00110, fm_pkg::ch_t'(c)}, rnd[23:16]);
		end
		for (int s = 0; s < 32; s++) begin
			wait_slot(fm_pkg::slot_t'(s));
			check_ch($sformatf("slot_data.ch[%0d]", s), exp_ch[s[2:0]], slot_data.ch);
		end
		end_test("channel groups", e0);
	endtask

	task automatic test_keyon();
		logic [31:0] rnd;
		fm_pkg::ch_t chans [4] = '{3'd0, 3'd3, 3'd5, 3'd6};
		int          e0;
		e0 = errors;
		foreach (chans[i]) begin
			rnd = $random(seed);
			reg_write(8'h08, {1'b0, rnd[3:0], chans[i]});
		end
		scan_keyon();
		foreach (chans[i])
			reg_write(8'h08, {5'b00000, chans[i]});    // All operators off
		scan_keyon();
		end_test("key-on", e0);
	endtask

	task automatic test_carrier();
		logic [31:0]   rnd;
		fm_pkg::slot_t s;
		int            e0;
		e0 = errors;
		for (int con = 0; con < 8; con++) begin
			rnd = $random(seed);
			reg_write(8'h22, {rnd[7:3], con[2:0]});
			for (int op = 0; op < 4; op++) begin
				s = {op[1:0], 3'd2};
				wait_slot(s);
				check_bit($sformatf("slot_data.carrier[%0d] con %0d", s, con),
					expected_carrier(con[2:0], op[1:0]), slot_data.carrier);
			end
		end
		end_test("carrier decode", e0);
	endtask

	task automatic test_busy_rules();
		logic [31:0]      rnd;
		fm_pkg::fm_data_t first;
		fm_pkg::fm_addr_t bad [5] = '{8'h00, 8'h09, 8'h38, 8'hA5, 8'hC0};
		int               e0;
		e0 = errors;
		rnd   = $random(seed);
		first = {1'b0, rnd[6:0]};
		strobe_write({3'b011, busy_slot}, first);
		model_write({3'b011, busy_slot}, first);
		check_bit("busy", 1'b1, busy);
		strobe_write({3'b011, busy_slot}, first ^ 8'h7F);    // Lands while busy
		wait_idle();
		check_slot_op(busy_slot);
		foreach (bad[i]) begin
			strobe_write(bad[i], rnd[15:8]);
			check_bit($sformatf("busy after addr %h", bad[i]), 1'b0, busy);
		end
		end_test("busy rules", e0);
	endtask

	initial begin
		seed = 32'hb1fd81a6;
		wr   = 1'b0;
		addr = '0;
		din  = '0;
		busy_slot = '0;
		for (int i = 0; i < 32; i++) begin
			exp_kon[i]   = 1'b0;
			op_groups[i] = 4'h0;
		end
		@(negedge rst);
		@(posedge clk);
		#1;
		test_reset_state();
		test_operator_groups();
		test_channel_groups();
		test_keyon();
		test_carrier();
		test_busy_rules();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- fm_regs_top.f
fm_pkg.sv
fm_scan_ctrl.sv
fm_slot_regs.sv
fm_keyon.sv
fm_slot_out.sv
fm_regs_top.sv
tb_clock.sv
tb_fm_regs.sv

//--- run.sh
#!/bin/sh
# Compile and run the FM register block testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_fm_regs -f fm_regs_top.f
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/Vtb_fm_regs > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Done: no errors$" sim.log; then
	exit 0
fi
exit 1
